// File: hw/vtl_pkg.sv
/* shared raster constants, palette, enums and structs for the text-mode video core;
   modules pull these in with a wildcard import in their header */
package vtl_pkg;

	// horizontal timing in F14M pixel clocks
	localparam logic [9:0] HSW       = 10'd66;   // hsync width
	localparam logic [9:0] HBP       = 10'd78;   // back porch
	localparam logic [9:0] HFP       = 10'd10;   // front porch
	localparam logic [9:0] H_VISIBLE = 10'd798;
	localparam logic [9:0] H_TOTAL   = 10'd952;  // 14.78 MHz / (952 * 312) ~ 49.7 Hz

	localparam logic [9:0] V_TOTAL     = 10'd312;
	localparam logic [9:0] VSYNC_LINES = 10'd2;

	localparam logic [9:0] ACTIVE_WIDTH  = 10'd640;
	localparam logic [9:0] ACTIVE_HEIGHT = 10'd192;
	localparam logic [9:0] LEFT_BORDER   = 10'd72;
	localparam logic [9:0] TOP_BORDER    = 10'd64;
	localparam logic [9:0] ACTIVE_X0     = HSW + HBP + LEFT_BORDER;  // 216

	// first video RAM read of a line, row base goes out here
	localparam logic [9:0] LOAD_COL_TEXT80 = ACTIVE_X0 - 10'd9;   // 207
	localparam logic [9:0] LOAD_COL_TEXT40 = ACTIVE_X0 - 10'd17;  // 199
	localparam logic [9:0] FETCH_SPAN      = 10'd632;  // 80 reads, 8 clocks apart

	// 12-bit rgb, 4 bits per gun
	localparam logic [11:0] PALETTE [16] = '{
		12'h000,  // black
		12'h00f,  // blue
		12'h080,  // green
		12'h09f,  // cyan
		12'h600,  // red
		12'h83f,  // magenta
		12'h780,  // yellow
		12'hccc,  // light grey
		12'h667,  // dark grey
		12'h88f,  // bright blue
		12'h5e3,  // bright green
		12'h8cf,  // bright cyan
		12'hf59,  // bright red
		12'hf9f,  // bright magenta
		12'hee6,  // bright yellow
		12'hfff   // white
	};

	localparam logic [3:0] RESET_BORDER        = 4'd10;
	localparam logic [3:0] RESET_FG            = 4'd15;
	localparam logic [3:0] RESET_BG            = 4'd1;
	localparam logic [3:0] FORCED_BLANK_COLOUR = 4'd12;

	localparam logic [7:0] PORT_MODE    = 8'h44;
	localparam logic [7:0] PORT_COLOURS = 8'h45;

	localparam int    CHARSET_GLYPHS = 64;
	localparam string CHARSET_FILE   = "hw/charset.hex";

	// hcnt[2:0], T0..T3 video owns the bus, T4..T7 the cpu
	typedef enum logic [2:0] {
		SLOT_T0, SLOT_T1, SLOT_T2, SLOT_T3,
		SLOT_T4, SLOT_T5, SLOT_T6, SLOT_T7
	} slot_t;

	typedef enum logic {
		MODE_TEXT40 = 1'b0,
		MODE_TEXT80 = 1'b1
	} text_mode_t;

	typedef struct packed {
		text_mode_t mode;
		logic       page_7;  // video RAM in page 7, else page 3
		logic [3:0] border;
		logic [3:0] fg;      // TEXT80 colours
		logic [3:0] bg;
	} vdc_config_t;

	localparam vdc_config_t RESET_CONFIG = '{
		mode: MODE_TEXT80, page_7: 1'b1, border: RESET_BORDER, fg: RESET_FG, bg: RESET_BG
	};

	typedef struct packed {
		logic       valid;
		logic [7:0] port;
		logic [7:0] data;
	} port_write_t;

	typedef struct packed {
		logic [9:0] hcnt;
		logic [9:0] vcnt;
		logic [7:0] ycnt;       // line within the active area
		logic       in_blank;
		logic       in_border;
		slot_t      phase;
	} raster_t;

endpackage

// File: hw/vtl_charset_rom.sv
`timescale 1ns/1ps
/* charset ROM, 64 glyphs x 8 lines, registered output one clock after addr */
module vtl_charset_rom import vtl_pkg::*; (
	input  logic       F14M,
	input  logic [8:0] addr,   // glyph * 8 + line
	output logic [7:0] q
);
	logic [7:0] mem [CHARSET_GLYPHS * 8];

	initial begin
		$readmemh(CHARSET_FILE, mem);
	end

	always_ff @(posedge F14M) begin
		q <= mem[addr];
	end

endmodule

// File: hw/vtl_raster_timing.sv
`timescale 1ns/1ps
/* 952 x 312 raster counters with syncs, bus slot, cpu clock enables and
   the blank and border flags that the fetch and pixel stages run from */
module vtl_raster_timing import vtl_pkg::*; (
	input  logic    F14M,
	input  logic    RESET,
	output raster_t raster,
	output logic    hsync,
	output logic    vsync,
	output logic    CPUCK,
	output logic    CPUENA
);
	logic [9:0] hcnt;
	logic [9:0] vcnt;
	logic [7:0] ycnt;
	slot_t      phase;

	always_ff @(posedge F14M) begin
		if (RESET) begin
			hcnt <= '0;
			vcnt <= '0;
			ycnt <= '0;
		end else if (hcnt == H_TOTAL - 10'd1) begin
			hcnt <= '0;
			vcnt <= (vcnt == V_TOTAL - 10'd1) ? 10'd0 : vcnt + 10'd1;
			// active line count starts with the first line below the top border
			if (vcnt == TOP_BORDER - 10'd1)
				ycnt <= '0;
			else
				ycnt <= ycnt + 8'd1;
		end else begin
			hcnt <= hcnt + 10'd1;
		end
	end

	assign phase = slot_t'(hcnt[2:0]);  // 8-clock bus cycle

	// both syncs active low
	assign hsync = !(hcnt < HSW);
	assign vsync = !(vcnt < VSYNC_LINES);

	assign CPUCK  = hcnt[1];  // F14M / 4
	assign CPUENA = (phase == SLOT_T2);

	always_comb begin
		raster.hcnt  = hcnt;
		raster.vcnt  = vcnt;
		raster.ycnt  = ycnt;
		raster.phase = phase;
		raster.in_blank = (hcnt < HSW + HBP) || (hcnt >= HSW + HBP + H_VISIBLE) ||
			(vcnt < VSYNC_LINES);
		raster.in_border = (hcnt < ACTIVE_X0) || (hcnt >= ACTIVE_X0 + ACTIVE_WIDTH) ||
			(vcnt < TOP_BORDER) || (vcnt >= TOP_BORDER + ACTIVE_HEIGHT);
	end

	// hcnt stays inside the 952-clock line
	a_hcnt_range: assert property (@(posedge F14M) disable iff (RESET)
		hcnt < H_TOTAL);

endmodule

// File: hw/vtl_io_ports.sv
`timescale 1ns/1ps
/* video configuration registers behind I/O ports 0x44 and 0x45, written by the
   cpu in its T2 slot and visible to the raster pipeline from the next clock */
module vtl_io_ports import vtl_pkg::*; (
	input  logic        F14M,
	input  logic        RESET,
	input  logic        cpu_en,   // CPUENA, cpu bus cycle in T2
	input  port_write_t port_wr,
	output vdc_config_t cfg
);
	logic wr_take;

	assign wr_take = cpu_en && port_wr.valid;

	always_ff @(posedge F14M) begin
		if (RESET) begin
			cfg <= RESET_CONFIG;
		end else if (wr_take) begin
			case (port_wr.port)
				PORT_MODE: begin
					cfg.page_7 <= !port_wr.data[3];  // bit 3 low = page 7
					cfg.mode   <= port_wr.data[0] ? MODE_TEXT80 : MODE_TEXT40;
					cfg.border <= port_wr.data[7:4];
				end
				PORT_COLOURS: begin
					cfg.fg <= port_wr.data[7:4];
					cfg.bg <= port_wr.data[3:0];
				end
				default: ;  // other ports belong elsewhere
			endcase
		end
	end

	// border follows a sampled 0x44 write and nothing else
	a_border_write: assert property (@(posedge F14M) disable iff (RESET)
		$changed(cfg.border) |-> $past(wr_take && port_wr.port == PORT_MODE));

endmodule

// File: hw/vtl_text_fetch.sv
`timescale 1ns/1ps
/* TEXT80 and TEXT40 fetch with one video RAM read per T7 and the byte latched in T0;
   the charset ROM is addressed from the latched code and feeds the shifter */
module vtl_text_fetch import vtl_pkg::*; (
	input  logic        F14M,
	input  logic        RESET,
	input  raster_t     raster,
	input  vdc_config_t cfg,
	input  logic [7:0]  vram_data,
	input  logic [7:0]  rom_q,
	output logic        vram_rd,
	output logic [17:0] vram_addr,
	output logic [8:0]  rom_addr,
	output logic [7:0]  glyph,
	output logic [7:0]  attr,
	output logic        glyph_load
);
	logic        text80;
	logic [9:0]  load_col;     // hcnt of the first read in a line
	logic        active_line;
	logic        fetch_win;
	logic [13:0] row_base;
	logic [13:0] addr_cnt;     // next offset after the row base
	logic [13:0] rd_offset;
	logic        rd_d;         // read data arrives this clock
	logic [7:0]  char_q;

	assign text80 = (cfg.mode == MODE_TEXT80);

	// TEXT40 needs char and attribute before the cell, so it starts one cell earlier
	assign load_col = text80 ? LOAD_COL_TEXT80 : LOAD_COL_TEXT40;

	assign active_line = (raster.vcnt >= TOP_BORDER) &&
		(raster.vcnt < TOP_BORDER + ACTIVE_HEIGHT);
	assign fetch_win = active_line && (raster.hcnt >= load_col) &&
		(raster.hcnt <= load_col + FETCH_SPAN);

	// row base interleaves the character lines of y
	assign row_base = {3'b111, raster.ycnt[5:3], raster.ycnt[7:6], raster.ycnt[7:6], 4'b0000};

	assign rd_offset = (raster.hcnt == load_col) ? row_base : addr_cnt;

	assign vram_rd   = fetch_win && (raster.phase == SLOT_T7);
	assign vram_addr = {(cfg.page_7 ? 4'h7 : 4'h3), rd_offset};

	always_ff @(posedge F14M) begin
		if (RESET) begin
			addr_cnt <= '0;
			rd_d     <= 1'b0;
		end else begin
			rd_d <= vram_rd;
			if (vram_rd)
				addr_cnt <= rd_offset + 14'd1;  // one step per read (char then attr in TEXT40)
		end
	end

	// T0 latch where TEXT40 alternates char (hcnt[3] set) and attribute
	always_ff @(posedge F14M) begin
		if (rd_d) begin
			if (text80 || raster.hcnt[3])
				char_q <= vram_data;
			else
				attr <= vram_data;
		end
	end

	// code taken mod 64 into 64 glyphs of 8 lines
	assign rom_addr = {char_q[5:0], raster.ycnt[2:0]};

	// ROM has held the glyph since T2 and the shifter takes it at the last clock of a cell
	assign glyph      = rom_q;
	assign glyph_load = (raster.phase == SLOT_T7) && (text80 || !raster.hcnt[3]);

	a_rd_pulse: assert property (@(posedge F14M) disable iff (RESET)
		vram_rd |=> !vram_rd);

endmodule

// File: hw/vtl_pixel_out.sv
`timescale 1ns/1ps
/* glyph shifter and pixel priority: blank, forced blank, border, text pixel;
   registered colour index looked up in the 16-entry palette */
module vtl_pixel_out import vtl_pkg::*; (
	input  logic        F14M,
	input  logic        RESET,
	input  raster_t     raster,
	input  vdc_config_t cfg,
	input  logic        blank,       // forced blank input
	input  logic [7:0]  glyph,
	input  logic [7:0]  attr,
	input  logic        glyph_load,
	output logic [5:0]  r,
	output logic [5:0]  g,
	output logic [5:0]  b
);
	logic [7:0]  shreg;   // glyph bits, LSB shown first
	logic [7:0]  attr_q;  // TEXT40 colours for the cell on screen
	logic        text80;
	logic        shift_en;
	logic [3:0]  fg;
	logic [3:0]  bg;
	logic [3:0]  pixel;
	logic [11:0] rgb;

	assign text80 = (cfg.mode == MODE_TEXT80);

	// TEXT40 doubles each bit, ACTIVE_X0 is even so odd hcnt is the second half
	assign shift_en = text80 || raster.hcnt[0];

	always_ff @(posedge F14M) begin
		if (glyph_load) begin
			shreg  <= glyph;  // wins over the shift of the last bit
			attr_q <= attr;
		end else if (shift_en) begin
			shreg <= shreg >> 1;
		end
	end

	assign fg = text80 ? cfg.fg : attr_q[7:4];
	assign bg = text80 ? cfg.bg : attr_q[3:0];

	always_ff @(posedge F14M) begin
		if (RESET)
			pixel <= 4'd0;
		else if (raster.in_blank)
			pixel <= 4'd0;                 // retrace, black
		else if (blank)
			pixel <= FORCED_BLANK_COLOUR;
		else if (raster.in_border)
			pixel <= cfg.border;
		else
			pixel <= shreg[0] ? fg : bg;
	end

	// 4 bits per gun, low two bits of the dac tied off
	assign rgb = PALETTE[pixel];
	assign r   = {rgb[11:8], 2'b00};
	assign g   = {rgb[7:4], 2'b00};
	assign b   = {rgb[3:0], 2'b00};

endmodule

// File: hw/vtl_video_top.sv
`timescale 1ns/1ps
/* video chip top: raster timing, I/O port registers, text fetch, charset ROM
   and pixel output; video RAM sits outside and answers one clock after vram_rd */
module vtl_video_top import vtl_pkg::*; (
	input  logic        F14M,       // pixel clock
	input  logic        RESET,
	input  logic        IORQ_n,
	input  logic        WR_n,
	input  logic [15:0] A,
	input  logic [7:0]  DO,         // cpu data out
	input  logic        blank,      // forced blank
	input  logic [7:0]  vram_data,
	output logic        CPUCK,
	output logic        CPUENA,
	output logic        hsync,
	output logic        vsync,
	output logic [5:0]  r,
	output logic [5:0]  g,
	output logic [5:0]  b,
	output logic        vram_rd,
	output logic [17:0] vram_addr
);
	raster_t     raster;
	vdc_config_t cfg;
	port_write_t port_wr;
	logic [8:0]  rom_addr;
	logic [7:0]  rom_q;
	logic [7:0]  glyph;
	logic [7:0]  attr;
	logic        glyph_load;

	// only the low address byte selects an I/O port
	assign port_wr = '{valid: !IORQ_n && !WR_n, port: A[7:0], data: DO};

	vtl_raster_timing u_raster (
		.F14M(F14M), .RESET(RESET), .raster(raster),
		.hsync(hsync), .vsync(vsync), .CPUCK(CPUCK), .CPUENA(CPUENA)
	);

	vtl_io_ports u_ports (
		.F14M(F14M), .RESET(RESET), .cpu_en(CPUENA), .port_wr(port_wr), .cfg(cfg)
	);

	vtl_text_fetch u_fetch (
		.F14M(F14M), .RESET(RESET), .raster(raster), .cfg(cfg),
		.vram_data(vram_data), .rom_q(rom_q),
		.vram_rd(vram_rd), .vram_addr(vram_addr), .rom_addr(rom_addr),
		.glyph(glyph), .attr(attr), .glyph_load(glyph_load)
	);

	vtl_charset_rom u_rom (
		.F14M(F14M), .addr(rom_addr), .q(rom_q)
	);

	vtl_pixel_out u_pixel (
		.F14M(F14M), .RESET(RESET), .raster(raster), .cfg(cfg), .blank(blank),
		.glyph(glyph), .attr(attr), .glyph_load(glyph_load),
		.r(r), .g(g), .b(b)
	);

endmodule

// File: dv/vtl_checker.sv
`timescale 1ns/1ps
/* reference raster, port and pixel model that watches the video core ports
   and compares syncs, cpu clocks, video RAM addresses and colours each clock */
module vtl_checker import vtl_pkg::*; (
	input  logic        F14M,
	input  logic        RESET,
	input  logic        IORQ_n,
	input  logic        WR_n,
	input  logic [15:0] A,
	input  logic [7:0]  DO,
	input  logic        blank,
	input  logic        hsync,
	input  logic        vsync,
	input  logic        CPUCK,
	input  logic        CPUENA,
	input  logic [5:0]  r,
	input  logic [5:0]  g,
	input  logic [5:0]  b,
	input  logic        vram_rd,
	input  logic [17:0] vram_addr,
	input  logic [7:0]  vram_mem [32768],
	output int          error_count,
	output int          check_count
);
	logic [7:0] rom [512];
	logic [9:0] mh;          // model hcnt
	logic [9:0] mv;          // model vcnt
	logic       c_text80;
	logic       c_page7;
	logic [3:0] c_border;
	logic [3:0] c_fg;
	logic [3:0] c_bg;
	logic [3:0] exp_idx;     // colour due in the next clock
	string      exp_test;

	initial begin
		$readmemh("hw/charset.hex", rom);
		error_count = 0;
		check_count = 0;
	end

	function automatic logic [13:0] row_base(input logic [7:0] y);
		return {3'b111, y[5:3], y[7:6], y[7:6], 4'b0000};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expv,
		input logic [31:0] actv);
		check_count++;
		if (expv !== actv) begin
			error_count++;
			if (error_count <= 20)
				$display("[FAIL] %s expected %0h actual %0h (line %0d, col %0d)",
					name, expv, actv, mv, mh);
		end
	endtask

	task automatic report_problem(input string msg);
		check_count++;
		error_count++;
		if (error_count <= 20)
			$display("%s (line %0d, col %0d)", msg, mv, mh);
	endtask

	// pixel rule in priority order
	function automatic logic [3:0] expected_index(input logic [9:0] h, input logic [9:0] v,
		input logic blk, output string test);
		logic [9:0]  x;
		logic [7:0]  y;
		logic [13:0] addr;
		logic [7:0]  ch;
		logic [7:0]  at;
		logic [7:0]  gl;
		if (h < 10'd144 || h >= 10'd942 || v < 10'd2) begin
			test = "blank";
			return 4'd0;
		end
		if (blk) begin
			test = "forced_blank";
			return 4'd12;
		end
		if (h < 10'd216 || h > 10'd855 || v < 10'd64 || v > 10'd255) begin
			test = "border";
			return c_border;
		end
		x = h - 10'd216;
		y = 8'(v - 10'd64);
		if (c_text80) begin
			test = "text80";
			addr = row_base(y) + {7'd0, x[9:3]};
			ch   = vram_mem[{c_page7, addr}];
			gl   = rom[{ch[5:0], y[2:0]}];
			return gl[x[2:0]] ? c_fg : c_bg;
		end
		test = "text40";
		addr = row_base(y) + {7'd0, x[9:4], 1'b0};  // char with its attribute next
		ch   = vram_mem[{c_page7, addr}];
		at   = vram_mem[{c_page7, addr + 14'd1}];
		gl   = rom[{ch[5:0], y[2:0]}];
		return gl[x[3:1]] ? at[7:4] : at[3:0];  // each bit shown twice
	endfunction

	always @(posedge F14M) begin
		logic [11:0] pal;
		logic [13:0] base;
		logic [13:0] off;
		string       name;
		if (RESET) begin
			mh        <= 10'd0;
			mv        <= 10'd0;
			c_text80  <= 1'b1;
			c_page7   <= 1'b1;
			c_border  <= RESET_BORDER;
			c_fg      <= RESET_FG;
			c_bg      <= RESET_BG;
			exp_idx   <= 4'd0;   // pixel register cleared
			exp_test  <= "reset";
		end else begin
			pal = PALETTE[exp_idx];
			check_value(exp_test, {14'd0, pal[11:8], 2'b00, pal[7:4], 2'b00, pal[3:0], 2'b00},
				{14'd0, r, g, b});
			check_value("hsync", 32'(mh >= 10'd66), 32'(hsync));
			check_value("vsync", 32'(mv >= 10'd2), 32'(vsync));
			check_value("cpuena", 32'(mh[2:0] == 3'd2), 32'(CPUENA));
			check_value("cpuck", 32'(mh[1]), 32'(CPUCK));

			if (vram_rd) begin
				check_value("vram_page", c_page7 ? 32'h7 : 32'h3, 32'(vram_addr[17:14]));
				off  = vram_addr[13:0];
				base = row_base(8'(mv - 10'd64));
				if (mv < 10'd64 || mv > 10'd255)
					report_problem("video RAM read outside the active lines");
				else if (off < base || off >= base + 14'd80)
					report_problem($sformatf("video RAM offset %0h outside row starting %0h",
						off, base));
			end

			exp_idx  <= expected_index(mh, mv, blank, name);
			exp_test <= name;

			// own 952 x 312 counters
			if (mh == 10'd951) begin
				mh <= 10'd0;
				mv <= (mv == 10'd311) ? 10'd0 : mv + 10'd1;
			end else begin
				mh <= mh + 10'd1;
			end

			// port write taken in T2 gives new config from the next clock
			if (mh[2:0] == 3'd2 && !IORQ_n && !WR_n) begin
				if (A[7:0] == PORT_MODE) begin
					c_page7  <= !DO[3];
					c_text80 <= DO[0];
					c_border <= DO[7:4];
				end else if (A[7:0] == PORT_COLOURS) begin
					c_fg <= DO[7:4];
					c_bg <= DO[3:0];
				end
			end
		end
	end

endmodule

// File: dv/tb_vtl_video.sv
`timescale 1ns/1ps
/* testbench top for the video core: clock, reset, three-frame port write schedule,
   forced blank on random lines and a two-page video RAM model; vtl_checker compares */
module tb_vtl_video import vtl_pkg::*; ();
	localparam int unsigned FRAME_CYCLES = 952 * 312;
	localparam int unsigned CYCLE_LIMIT  = 3 * FRAME_CYCLES;
	localparam logic [31:0] SEED         = 32'he59b639e;

	logic        F14M = 1'b0;
	logic        RESET = 1'b1;
	logic        IORQ_n = 1'b1;
	logic        WR_n = 1'b1;
	logic [15:0] A = 16'h0000;
	logic [7:0]  DO = 8'h00;
	logic        blank = 1'b0;
	logic [7:0]  vram_data = 8'h00;
	logic        CPUCK, CPUENA, hsync, vsync, vram_rd;
	logic [5:0]  r, g, b;
	logic [17:0] vram_addr;

	logic [7:0]  vram_mem [32768];  // page 3 low half, page 7 high half
	logic [31:0] lcg_state;
	logic [31:0] blank_state;       // own stream for forced blank
	logic        prev_hsync = 1'b1;
	int unsigned cycle_cnt = 0;
	int          error_count;
	int          check_count;

	always #50 F14M = ~F14M;  // 100 ns

	vtl_video_top u_dut (
		.F14M(F14M), .RESET(RESET), .IORQ_n(IORQ_n), .WR_n(WR_n), .A(A), .DO(DO),
		.blank(blank), .vram_data(vram_data), .CPUCK(CPUCK), .CPUENA(CPUENA),
		.hsync(hsync), .vsync(vsync), .r(r), .g(g), .b(b),
		.vram_rd(vram_rd), .vram_addr(vram_addr)
	);

	vtl_checker u_check (
		.F14M(F14M), .RESET(RESET), .IORQ_n(IORQ_n), .WR_n(WR_n), .A(A), .DO(DO),
		.blank(blank), .hsync(hsync), .vsync(vsync), .CPUCK(CPUCK), .CPUENA(CPUENA),
		.r(r), .g(g), .b(b), .vram_rd(vram_rd), .vram_addr(vram_addr),
		.vram_mem(vram_mem), .error_count(error_count), .check_count(check_count)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// video RAM answers one clock after the strobe, nibble bit 2 picks the page
	always @(posedge F14M) begin
		if (vram_rd)
			vram_data <= vram_mem[{vram_addr[16], vram_addr[13:0]}];
	end

	// new forced-blank decision at each line start, about one line in 16
	always @(posedge F14M) begin
		prev_hsync <= hsync;
		if (RESET) begin
			blank <= 1'b0;
		end else if (prev_hsync && !hsync) begin
			blank_state = lcg_next(blank_state);
			blank <= (blank_state[31:28] == 4'd0);
		end
	end

	always @(posedge F14M) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: frame schedule not done after %0d cycles", cycle_cnt);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic port_write(input logic [7:0] port, input logic [7:0] data);
		@(posedge F14M);
		IORQ_n <= 1'b0;
		WR_n   <= 1'b0;
		A      <= {8'h00, port};
		DO     <= data;
		do @(posedge F14M); while (!CPUENA);  // held through one T2 sample
		IORQ_n <= 1'b1;
		WR_n   <= 1'b1;
	endtask

	task automatic wait_vsync(input logic level);
		while (vsync !== level)
			@(posedge F14M);
	endtask

	task automatic wait_lines(input int n);
		int   seen;
		logic last;
		seen = 0;
		last = hsync;
		while (seen < n) begin
			@(posedge F14M);
			if (last && !hsync)
				seen++;
			last = hsync;
		end
	endtask

	initial begin
		lcg_state = SEED;
		for (int i = 0; i < 32768; i++) begin
			lcg_state = lcg_next(lcg_state);
			vram_mem[i] = lcg_state[23:16];
		end
		blank_state = lcg_next(lcg_state);
		repeat (2) @(posedge F14M);
		RESET <= 1'b0;

		wait_vsync(1'b1);  // frame 1 at reset defaults
		wait_vsync(1'b0);
		lcg_state = lcg_next(lcg_state);
		port_write(PORT_MODE, {lcg_state[19:16], lcg_state[24], 3'b000});  // TEXT40

		wait_vsync(1'b1);
		wait_vsync(1'b0);
		lcg_state = lcg_next(lcg_state);
		port_write(PORT_COLOURS, lcg_state[23:16]);
		lcg_state = lcg_next(lcg_state);
		port_write(PORT_MODE, {lcg_state[19:16], lcg_state[24], 3'b001});  // back to TEXT80

		wait_vsync(1'b1);
		wait_lines(256);  // through the last active line

		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: hw/charset.hex
// 64 glyphs x 8 lines, one byte per glyph line, bit 0 is the leftmost pixel
// each row holds two glyphs, glyph 2n in the first 8 bytes and glyph 2n+1 in the last 8
00 00 00 00 00 00 00 00 18 3c 66 7e 66 66 66 00
3e 66 66 3e 66 66 3e 00 3c 66 06 06 06 66 3c 00
1e 36 66 66 66 36 1e 00 7e 06 06 1e 06 06 7e 00
7e 06 06 1e 06 06 06 00 3c 66 06 76 66 66 3c 00
66 66 66 7e 66 66 66 00 3c 18 18 18 18 18 3c 00
60 60 60 60 60 66 3c 00 66 36 1e 0e 1e 36 66 00
06 06 06 06 06 06 7e 00 c6 ee fe d6 c6 c6 c6 00
66 6e 7e 7e 76 66 66 00 3c 66 66 66 66 66 3c 00
3e 66 66 3e 06 06 06 00 3c 66 66 66 66 3c 70 00
3e 66 66 3e 1e 36 66 00 3c 66 06 3c 60 66 3c 00
7e 18 18 18 18 18 18 00 66 66 66 66 66 66 3c 00
66 66 66 66 66 3c 18 00 c6 c6 c6 d6 fe ee c6 00
66 66 3c 18 3c 66 66 00 66 66 66 3c 18 18 18 00
7e 60 30 18 0c 06 7e 00 3c 0c 0c 0c 0c 0c 3c 00
00 06 0c 18 30 60 00 00 3c 30 30 30 30 30 3c 00
18 3c 7e 18 18 18 18 00 00 00 00 00 00 00 ff 00
00 00 00 00 00 00 00 00 18 18 18 18 00 00 18 00
66 66 66 00 00 00 00 00 66 66 ff 66 ff 66 66 00
18 7c 06 3c 60 3e 18 00 46 66 30 18 0c 66 62 00
1c 36 1c 6e 3b 33 6e 00 18 18 0c 00 00 00 00 00
30 18 0c 0c 0c 18 30 00 0c 18 30 30 30 18 0c 00
00 66 3c ff 3c 66 00 00 00 18 18 7e 18 18 00 00
00 00 00 00 00 18 18 0c 00 00 00 7e 00 00 00 00
00 00 00 00 00 18 18 00 00 60 30 18 0c 06 00 00
3c 66 76 7e 6e 66 3c 00 18 1c 18 18 18 18 7e 00
3c 66 60 30 0c 06 7e 00 3c 66 60 38 60 66 3c 00
30 38 3c 36 7e 30 30 00 7e 06 3e 60 60 66 3c 00
3c 66 06 3e 66 66 3c 00 7e 66 30 18 18 18 18 00
3c 66 66 3c 66 66 3c 00 3c 66 66 7c 60 66 3c 00
00 00 18 00 00 18 00 00 00 00 18 00 00 18 18 0c
70 18 0c 06 0c 18 70 00 00 00 7e 00 7e 00 00 00
0e 18 30 60 30 18 0e 00 3c 66 60 30 18 00 18 00

// File: sim.f
hw/vtl_pkg.sv
hw/vtl_charset_rom.sv
hw/vtl_raster_timing.sv
hw/vtl_io_ports.sv
hw/vtl_text_fetch.sv
hw/vtl_pixel_out.sv
hw/vtl_video_top.sv
dv/vtl_checker.sv
dv/tb_vtl_video.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = tb_vtl_video
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
